// File: logic/spritePkg.sv
// sprite rotator shared definitions
// widths, fixed-point formats, sprite and arctangent tables, register map
`default_nettype none

package spritePkg;

	localparam int apbAddrWidth = 12;
	localparam int apbDataWidth = 32;

	// point coordinates are signed with 4 fraction bits
	localparam int coordWidth = 12;
	localparam int coordFrac = 4;
	// angle in radians, 3 integer and 10 fraction bits
	localparam int angleWidth = 13;
	localparam int angleFrac = 10;
	localparam int pixelWidth = 8;

	localparam int cordicIters = 10;
	localparam int cordicLatency = cordicIters + 2;
	localparam int gainFrac = 10;
	localparam int cordicGain = 622;
	localparam logic signed [angleWidth-1:0] halfPi = 13'sd1608;

	// atan(2^-i) scaled by 2^angleFrac
	localparam logic signed [angleWidth-1:0] atanTable [0:cordicIters-1] = '{
		13'sd804, 13'sd475, 13'sd251, 13'sd127, 13'sd64,
		13'sd32, 13'sd16, 13'sd8, 13'sd4, 13'sd2
	};

	localparam int imageSize = 57;
	localparam int rowIndexWidth = 6;
	localparam int centreX = 27;
	localparam int centreY = 29;

	localparam int blockCount = 26;
	localparam int blockSide = 4;
	localparam int pointCount = blockCount * blockSide * blockSide;

	typedef struct packed {
		logic [5:0] x;
		logic [5:0] y;
	} blockOrigin;

	// top-left corner of each solid block of the sprite
	localparam blockOrigin blockOrigins [0:blockCount-1] = '{
		{6'd12, 6'd12}, {6'd40, 6'd12}, {6'd16, 6'd16}, {6'd20, 6'd16},
		{6'd32, 6'd16}, {6'd36, 6'd16}, {6'd20, 6'd20}, {6'd24, 6'd20},
		{6'd28, 6'd20}, {6'd32, 6'd20}, {6'd16, 6'd24}, {6'd20, 6'd24},
		{6'd32, 6'd24}, {6'd36, 6'd24}, {6'd20, 6'd28}, {6'd32, 6'd28},
		{6'd16, 6'd32}, {6'd20, 6'd32}, {6'd32, 6'd32}, {6'd36, 6'd32},
		{6'd20, 6'd36}, {6'd24, 6'd36}, {6'd28, 6'd36}, {6'd32, 6'd36},
		{6'd16, 6'd40}, {6'd36, 6'd40}
	};

	typedef enum logic [apbAddrWidth-1:0] {
		regCtrl = 12'h000,
		regTheta = 12'h004,
		regStatus = 12'h008,
		rowBase = 12'h100
	} regAddr;

	typedef enum logic [1:0] {
		stIdle,
		stIssue,
		stDrain
	} runState;

endpackage

`default_nettype wire

// File: logic/apbDecode.sv
// APB register slave for the sprite rotator
// holds the angle, issues start, returns status and bitmap row words
`timescale 1ns/1ps
`default_nettype none

module apbDecode (
	input wire logic clk,
	input wire logic reset,
	input wire logic pselI,
	input wire logic penableI,
	input wire logic pwriteI,
	input wire logic [spritePkg::apbAddrWidth-1:0] paddrI,
	input wire logic [spritePkg::apbDataWidth-1:0] pwdataI,
	output logic [spritePkg::apbDataWidth-1:0] prdataO,
	output logic preadyO,
	output logic pslverrO,
	input wire logic busyI,
	input wire logic doneI,
	input wire logic [spritePkg::imageSize-1:0] rowDataI,
	output logic startPulseO,
	output logic signed [spritePkg::angleWidth-1:0] thetaO,
	output logic [spritePkg::rowIndexWidth-1:0] readRowO
);

	logic access;
	logic rowHit;
	logic addrOk;
	logic busyRefuse;
	logic writeOk;
	logic [spritePkg::apbAddrWidth-1:0] rowOffset;
	logic [spritePkg::apbDataWidth-1:0] readData;
	logic signed [spritePkg::angleWidth-1:0] thetaReg;

	assign access = pselI & penableI;

	// row words sit at rowBase + 8*row, low word first
	assign rowOffset = paddrI - spritePkg::rowBase;
	assign rowHit = (paddrI >= spritePkg::rowBase)
		&& (rowOffset[spritePkg::apbAddrWidth-1:spritePkg::rowIndexWidth+3] == '0)
		&& (rowOffset[1:0] == 2'b00);
	assign readRowO = rowOffset[spritePkg::rowIndexWidth+2:3];

	always_comb begin
		addrOk = 1'b1;
		readData = '0;
		if (rowHit) begin
			addrOk = (readRowO < spritePkg::imageSize);
			if (rowOffset[2]) begin
				readData = {{(2 * spritePkg::apbDataWidth - spritePkg::imageSize){1'b0}},
					rowDataI[spritePkg::imageSize-1:spritePkg::apbDataWidth]};
			end else begin
				readData = rowDataI[spritePkg::apbDataWidth-1:0];
			end
		end else begin
			case (paddrI)
				spritePkg::regCtrl: readData = '0;
				spritePkg::regTheta: readData = {{(spritePkg::apbDataWidth -
					spritePkg::angleWidth){thetaReg[spritePkg::angleWidth-1]}}, thetaReg};
				spritePkg::regStatus: readData = {{(spritePkg::apbDataWidth-2){1'b0}},
					doneI, busyI};
				default: addrOk = 1'b0;
			endcase
		end
	end

	// control and angle are locked while a run is in progress
	assign busyRefuse = pwriteI && busyI
		&& ((paddrI == spritePkg::regCtrl) || (paddrI == spritePkg::regTheta));

	assign pslverrO = access && (!addrOk || busyRefuse);
	assign writeOk = access && pwriteI && !pslverrO;
	assign startPulseO = writeOk && (paddrI == spritePkg::regCtrl) && pwdataI[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			thetaReg <= '0;
		end else if (writeOk && (paddrI == spritePkg::regTheta)) begin
			thetaReg <= pwdataI[spritePkg::angleWidth-1:0];
		end
	end

	assign thetaO = thetaReg;
	assign prdataO = readData;
	assign preadyO = 1'b1;

endmodule

`default_nettype wire

// File: logic/pointSequencer.sv
// run controller that walks the sprite blocks
// emits one centred fixed-point point per cycle, then waits for the pipeline to drain
`timescale 1ns/1ps
`default_nettype none

module pointSequencer (
	input wire logic clk,
	input wire logic reset,
	input wire logic startPulseI,
	output logic busyO,
	output logic pointValidO,
	output logic signed [spritePkg::coordWidth-1:0] pointXO,
	output logic signed [spritePkg::coordWidth-1:0] pointYO
);

	spritePkg::runState state;
	logic [$clog2(spritePkg::blockCount)-1:0] blockIdx;
	logic [$clog2(spritePkg::blockSide * spritePkg::blockSide)-1:0] pixIdx;
	logic [$clog2(spritePkg::cordicLatency)-1:0] drainCount;
	spritePkg::blockOrigin origin;
	int pixX;
	int pixY;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= spritePkg::stIdle;
			blockIdx <= '0;
			pixIdx <= '0;
			drainCount <= '0;
		end else begin
			case (state)
				spritePkg::stIdle: begin
					if (startPulseI) begin
						state <= spritePkg::stIssue;
						blockIdx <= '0;
						pixIdx <= '0;
					end
				end
				spritePkg::stIssue: begin
					pixIdx <= pixIdx + 1'b1;
					if (pixIdx == spritePkg::blockSide * spritePkg::blockSide - 1) begin
						blockIdx <= blockIdx + 1'b1;
						if (blockIdx == spritePkg::blockCount - 1) begin
							state <= spritePkg::stDrain;
							drainCount <= '0;
						end
					end
				end
				spritePkg::stDrain: begin
					drainCount <= drainCount + 1'b1;
					if (drainCount == spritePkg::cordicLatency - 1) begin
						state <= spritePkg::stIdle;
					end
				end
				default: state <= spritePkg::stIdle;
			endcase
		end
	end

	// x offset is the outer loop within a block
	assign origin = spritePkg::blockOrigins[blockIdx];
	assign pixX = int'(origin.x) + int'(pixIdx) / spritePkg::blockSide - spritePkg::centreX;
	assign pixY = int'(origin.y) + int'(pixIdx) % spritePkg::blockSide - spritePkg::centreY;

	assign pointXO = {pixX[spritePkg::coordWidth-spritePkg::coordFrac-1:0],
		{spritePkg::coordFrac{1'b0}}};
	assign pointYO = {pixY[spritePkg::coordWidth-spritePkg::coordFrac-1:0],
		{spritePkg::coordFrac{1'b0}}};
	assign pointValidO = (state == spritePkg::stIssue);
	assign busyO = (state != spritePkg::stIdle);

endmodule

`default_nettype wire

// File: logic/cordicRotator.sv
// pipelined CORDIC point rotator
// quarter-turn pre-rotation, micro-rotations, then gain compensation and recentring
`timescale 1ns/1ps
`default_nettype none

module cordicRotator (
	input wire logic clk,
	input wire logic reset,
	input wire logic signed [spritePkg::angleWidth-1:0] thetaI,
	input wire logic pointValidI,
	input wire logic signed [spritePkg::coordWidth-1:0] pointXI,
	input wire logic signed [spritePkg::coordWidth-1:0] pointYI,
	output logic resultValidO,
	output logic signed [spritePkg::pixelWidth-1:0] resultXO,
	output logic signed [spritePkg::pixelWidth-1:0] resultYO
);

	logic signed [spritePkg::coordWidth-1:0] stX [0:spritePkg::cordicIters];
	logic signed [spritePkg::coordWidth-1:0] stY [0:spritePkg::cordicIters];
	logic signed [spritePkg::angleWidth-1:0] stZ [0:spritePkg::cordicIters];
	logic [spritePkg::cordicIters:0] validPipe;
	int scaledX;
	int scaledY;

	always_ff @(posedge clk) begin
		if (reset) begin
			validPipe <= '0;
			resultValidO <= 1'b0;
		end else begin
			validPipe <= {validPipe[spritePkg::cordicIters-1:0], pointValidI};
			resultValidO <= validPipe[spritePkg::cordicIters];
		end
	end

	// bring the residual angle inside the CORDIC convergence range
	always_ff @(posedge clk) begin
		if (thetaI > spritePkg::halfPi) begin
			stX[0] <= -pointYI;
			stY[0] <= pointXI;
			stZ[0] <= thetaI - spritePkg::halfPi;
		end else if (thetaI < -spritePkg::halfPi) begin
			stX[0] <= pointYI;
			stY[0] <= -pointXI;
			stZ[0] <= thetaI + spritePkg::halfPi;
		end else begin
			stX[0] <= pointXI;
			stY[0] <= pointYI;
			stZ[0] <= thetaI;
		end
	end

	for (genvar i = 0; i < spritePkg::cordicIters; i++) begin : gMicro
		always_ff @(posedge clk) begin
			// non-negative residual rotates counter-clockwise
			if (!stZ[i][spritePkg::angleWidth-1]) begin
				stX[i+1] <= stX[i] - (stY[i] >>> i);
				stY[i+1] <= stY[i] + (stX[i] >>> i);
				stZ[i+1] <= stZ[i] - spritePkg::atanTable[i];
			end else begin
				stX[i+1] <= stX[i] + (stY[i] >>> i);
				stY[i+1] <= stY[i] - (stX[i] >>> i);
				stZ[i+1] <= stZ[i] + spritePkg::atanTable[i];
			end
		end
	end

	// undo the CORDIC gain, round to whole pixels, move back to the centre
	always_comb begin
		scaledX = int'(stX[spritePkg::cordicIters]) * spritePkg::cordicGain
			+ (1 <<< (spritePkg::gainFrac + spritePkg::coordFrac - 1));
		scaledY = int'(stY[spritePkg::cordicIters]) * spritePkg::cordicGain
			+ (1 <<< (spritePkg::gainFrac + spritePkg::coordFrac - 1));
		scaledX = (scaledX >>> (spritePkg::gainFrac + spritePkg::coordFrac)) + spritePkg::centreX;
		scaledY = (scaledY >>> (spritePkg::gainFrac + spritePkg::coordFrac)) + spritePkg::centreY;
	end

	always_ff @(posedge clk) begin
		resultXO <= scaledX[spritePkg::pixelWidth-1:0];
		resultYO <= scaledY[spritePkg::pixelWidth-1:0];
	end

endmodule

`default_nettype wire

// File: logic/bitmapStore.sv
// one-bit bitmap of the rotated sprite
// cleared on start, pixels set by rotator results, rows read combinationally
`timescale 1ns/1ps
`default_nettype none

module bitmapStore (
	input wire logic clk,
	input wire logic reset,
	input wire logic startPulseI,
	input wire logic busyI,
	input wire logic resultValidI,
	input wire logic signed [spritePkg::pixelWidth-1:0] resultXI,
	input wire logic signed [spritePkg::pixelWidth-1:0] resultYI,
	input wire logic [spritePkg::rowIndexWidth-1:0] readRowI,
	output logic [spritePkg::imageSize-1:0] rowDataO,
	output logic doneO
);

	logic [spritePkg::imageSize-1:0] rows [0:spritePkg::imageSize-1];
	logic busyPrev;
	logic inRange;

	// points that land outside the bitmap are dropped
	assign inRange = (resultXI >= 0) && (resultXI < spritePkg::imageSize)
		&& (resultYI >= 0) && (resultYI < spritePkg::imageSize);

	always_ff @(posedge clk) begin
		if (reset || startPulseI) begin
			for (int r = 0; r < spritePkg::imageSize; r++) begin
				rows[r] <= '0;
			end
		end else if (resultValidI && inRange) begin
			rows[resultYI[spritePkg::rowIndexWidth-1:0]][resultXI[spritePkg::rowIndexWidth-1:0]] <= 1'b1;
		end
	end

	// done follows the end of busy and holds until the next start
	always_ff @(posedge clk) begin
		if (reset) begin
			busyPrev <= 1'b0;
			doneO <= 1'b0;
		end else begin
			busyPrev <= busyI;
			if (startPulseI) begin
				doneO <= 1'b0;
			end else if (busyPrev && !busyI) begin
				doneO <= 1'b1;
			end
		end
	end

	assign rowDataO = (readRowI < spritePkg::imageSize) ? rows[readRowI] : '0;

endmodule

`default_nettype wire

// File: logic/spriteRotator.sv
// sprite rotator top level
// APB register slave, point sequencer, CORDIC rotator and bitmap store
`timescale 1ns/1ps
`default_nettype none

module spriteRotator (
	input wire logic clk,
	input wire logic reset,
	input wire logic pselI,
	input wire logic penableI,
	input wire logic pwriteI,
	input wire logic [spritePkg::apbAddrWidth-1:0] paddrI,
	input wire logic [spritePkg::apbDataWidth-1:0] pwdataI,
	output logic [spritePkg::apbDataWidth-1:0] prdataO,
	output logic preadyO,
	output logic pslverrO
);

	logic startPulse;
	logic busy;
	logic doneFlag;
	logic signed [spritePkg::angleWidth-1:0] theta;
	logic [spritePkg::rowIndexWidth-1:0] readRow;
	logic [spritePkg::imageSize-1:0] rowData;
	logic pointValid;
	logic signed [spritePkg::coordWidth-1:0] pointX;
	logic signed [spritePkg::coordWidth-1:0] pointY;
	logic resultValid;
	logic signed [spritePkg::pixelWidth-1:0] resultX;
	logic signed [spritePkg::pixelWidth-1:0] resultY;

	apbDecode i_apbDecode (
		.clk(clk), .reset(reset),
		.pselI(pselI), .penableI(penableI), .pwriteI(pwriteI),
		.paddrI(paddrI), .pwdataI(pwdataI),
		.prdataO(prdataO), .preadyO(preadyO), .pslverrO(pslverrO),
		.busyI(busy), .doneI(doneFlag), .rowDataI(rowData),
		.startPulseO(startPulse), .thetaO(theta), .readRowO(readRow)
	);

	pointSequencer i_pointSequencer (
		.clk(clk), .reset(reset), .startPulseI(startPulse),
		.busyO(busy), .pointValidO(pointValid), .pointXO(pointX), .pointYO(pointY)
	);

	cordicRotator i_cordicRotator (
		.clk(clk), .reset(reset), .thetaI(theta),
		.pointValidI(pointValid), .pointXI(pointX), .pointYI(pointY),
		.resultValidO(resultValid), .resultXO(resultX), .resultYO(resultY)
	);

	bitmapStore i_bitmapStore (
		.clk(clk), .reset(reset), .startPulseI(startPulse), .busyI(busy),
		.resultValidI(resultValid), .resultXI(resultX), .resultYI(resultY),
		.readRowI(readRow), .rowDataO(rowData), .doneO(doneFlag)
	);

endmodule

`default_nettype wire

// File: testbench/clockGen.sv
// testbench clock and reset source
// 100 ns clock, reset held high for the first two cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/spriteRotatorTb.sv
// sprite rotator testbench
// APB register traffic, bitmap reference model and row-by-row comparison
`timescale 1ns/1ps
`default_nettype none

module spriteRotatorTb;

	localparam int runCycles = spritePkg::pointCount + spritePkg::cordicLatency + 50;
	// three cycles per APB transfer, two words per row
	localparam int readbackCycles = 3 * 2 * spritePkg::imageSize;
	localparam int cycleLimit = 10 * (runCycles + readbackCycles) + 2000;
	localparam int piAngle = 3217;
	localparam int quarterPi = 804;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [spritePkg::imageSize-1:0] expRows [0:spritePkg::imageSize-1];
	logic [31:0] lcgState = 32'd48645;
	int errorCount = 0;
	int cycleCount = 0;
	int angle;

	clockGen i_clockGen (.clk(clk), .reset(reset));

	spriteRotator i_spriteRotator (
		.clk(clk), .reset(reset),
		.pselI(psel), .penableI(penable), .pwriteI(pwrite),
		.paddrI(paddr), .pwdataI(pwdata),
		.prdataO(prdata), .preadyO(pready), .pslverrO(pslverr)
	);

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: tests did not finish within %0d cycles", cycleLimit);
			$display("Errors: %0d failed checks", errorCount);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected,
				actual);
		end
	endtask

	// setup cycle, access cycle, sample mid access cycle
	task automatic apbTransfer(input logic write, input logic [11:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		compareValue("preadyO", 32'd1, {31'd0, pready});
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic writeExpect(input logic [11:0] addr, input logic [31:0] data,
		input logic expErr, input string name);
		logic [31:0] rdata;
		logic err;
		apbTransfer(1'b1, addr, data, rdata, err);
		compareValue({name, " pslverrO"}, {31'd0, expErr}, {31'd0, err});
	endtask

	task automatic readExpect(input logic [11:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] rdata;
		logic err;
		apbTransfer(1'b0, addr, 32'd0, rdata, err);
		compareValue(name, expected, rdata);
		compareValue({name, " pslverrO"}, 32'd0, {31'd0, err});
	endtask

	task automatic readError(input logic [11:0] addr, input string name);
		logic [31:0] rdata;
		logic err;
		apbTransfer(1'b0, addr, 32'd0, rdata, err);
		compareValue({name, " pslverrO"}, 32'd1, {31'd0, err});
	endtask

	function automatic int nextAngle(input int lo, input int hi);
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lo + int'(lcgState[31:16] % (hi - lo + 1));
	endfunction

	// expected bitmap: centre each sprite pixel, rotate, undo gain, recentre
	task automatic buildExpected(input int theta);
		int b;
		int p;
		int i;
		int r;
		int x;
		int y;
		int z;
		int nx;
		int rx;
		int ry;
		for (r = 0; r < spritePkg::imageSize; r++) begin
			expRows[r] = '0;
		end
		for (b = 0; b < spritePkg::blockCount; b++) begin
			for (p = 0; p < spritePkg::blockSide * spritePkg::blockSide; p++) begin
				x = (int'(spritePkg::blockOrigins[b].x) + p / spritePkg::blockSide
					- spritePkg::centreX) * (1 << spritePkg::coordFrac);
				y = (int'(spritePkg::blockOrigins[b].y) + p % spritePkg::blockSide
					- spritePkg::centreY) * (1 << spritePkg::coordFrac);
				z = theta;
				if (theta > 1608) begin
					nx = -y;
					y = x;
					x = nx;
					z = theta - 1608;
				end else if (theta < -1608) begin
					nx = y;
					y = -x;
					x = nx;
					z = theta + 1608;
				end
				for (i = 0; i < spritePkg::cordicIters; i++) begin
					if (z >= 0) begin
						nx = x - (y >>> i);
						y = y + (x >>> i);
						z = z - int'(spritePkg::atanTable[i]);
					end else begin
						nx = x + (y >>> i);
						y = y - (x >>> i);
						z = z + int'(spritePkg::atanTable[i]);
					end
					x = nx;
				end
				rx = ((x * spritePkg::cordicGain + 8192) >>> 14) + spritePkg::centreX;
				ry = ((y * spritePkg::cordicGain + 8192) >>> 14) + spritePkg::centreY;
				if (rx >= 0 && rx < spritePkg::imageSize && ry >= 0
					&& ry < spritePkg::imageSize) begin
					expRows[ry][rx] = 1'b1;
				end
			end
		end
	endtask

	// low word bits 31..0, high word bits 56..32 zero-extended
	task automatic compareRows(input string tag);
		int r;
		logic [11:0] addr;
		for (r = 0; r < spritePkg::imageSize; r++) begin
			addr = 12'h100 + 12'(8 * r);
			readExpect(addr, expRows[r][31:0], $sformatf("%s row %0d low", tag, r));
			readExpect(addr + 12'd4, {7'd0, expRows[r][56:32]},
				$sformatf("%s row %0d high", tag, r));
		end
	endtask

	task automatic startRun(input int theta);
		writeExpect(12'h004, 32'(theta), 1'b0, "theta write");
		readExpect(12'h004, 32'(theta), "theta readback");
		writeExpect(12'h000, 32'd1, 1'b0, "start write");
	endtask

	task automatic finishRun(input int theta, input string tag);
		logic [31:0] status;
		logic err;
		status = '0;
		while (!status[1]) begin
			apbTransfer(1'b0, 12'h008, 32'd0, status, err);
		end
		compareValue({tag, " status at done"}, 32'h2, status);
		buildExpected(theta);
		compareRows(tag);
	endtask

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		wait (reset === 1'b0);

		// registers and bitmap after reset
		readExpect(12'h008, 32'd0, "status after reset");
		readExpect(12'h004, 32'd0, "theta after reset");
		readExpect(12'h000, 32'd0, "ctrl after reset");
		for (int r = 0; r < spritePkg::imageSize; r++) begin
			expRows[r] = '0;
		end
		compareRows("reset");

		startRun(0);
		finishRun(0, "angle zero");

		// two runs inside +-pi/2, two above, two below
		for (int k = 0; k < 6; k++) begin
			case (k / 2)
				0: angle = nextAngle(-1608, 1608);
				1: angle = nextAngle(1609, 3216);
				default: angle = nextAngle(-3216, -1609);
			endcase
			startRun(angle);
			finishRun(angle, $sformatf("angle %0d", angle));
		end

		// accesses refused while busy, bad addresses
		startRun(500);
		readExpect(12'h008, 32'h1, "status while busy");
		writeExpect(12'h004, 32'd100, 1'b1, "theta write while busy");
		writeExpect(12'h000, 32'd1, 1'b1, "start while busy");
		readExpect(12'h004, 32'd500, "theta after refused write");
		readError(12'h00C, "unmapped address");
		readError(12'h100 + 12'(8 * 57), "row 57");
		readError(12'h100 + 12'(8 * 63), "row 63");
		finishRun(500, "held angle");

		// second run must clear the first run's pixels
		startRun(piAngle);
		finishRun(piAngle, "angle pi");
		startRun(quarterPi);
		readExpect(12'h008, 32'h1, "status on restart");
		finishRun(quarterPi, "angle pi/4");

		$display("Errors: %0d failed checks", errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cordicSprite.f
logic/spritePkg.sv
logic/apbDecode.sv
logic/pointSequencer.sv
logic/cordicRotator.sv
logic/bitmapStore.sv
logic/spriteRotator.sv
testbench/clockGen.sv
testbench/spriteRotatorTb.sv
